// File: hw/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // 32-bit address split as tag / index / byte offset
    localparam int TAG_W          = 20;
    localparam int INDEX_W        = 8;
    localparam int OFFSET_W       = 4;
    localparam int WORDS_PER_LINE = 4;
    localparam int NUM_SETS       = 256;

    typedef logic [31:0]                  word_t;
    typedef logic [3:0]                   strb_t;
    typedef logic [TAG_W-1:0]             tag_t;
    typedef logic [INDEX_W-1:0]           index_t;
    // word 0 in the low bits
    typedef logic [WORDS_PER_LINE*32-1:0] line_t;

    typedef struct packed {
        tag_t                tag;
        index_t              index;
        logic [OFFSET_W-1:0] offset;
    } cpu_addr_t;

    typedef struct packed {
        logic      op;
        cpu_addr_t addr;
        strb_t     wstrb;
        word_t     wdata;
    } cpu_req_t;

    typedef logic way_sel_t;

    // what a way reports for the set on its index
    typedef struct packed {
        logic  hit;
        logic  valid;
        logic  dirty;
        tag_t  tag;
        line_t line;
        word_t load_word;
    } way_status_t;

    typedef struct packed {
        logic  tag_we;
        logic  line_we;
        logic  dirty;
        tag_t  tag;
        line_t line;
    } way_write_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        miss,
        replace,
        refill
    } cache_state_t;

endpackage

`default_nettype wire

// File: hw/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    // line address with the offset bits at zero
    typedef logic [31:0] mem_rd_req_t;

    // whole-line write-back
    typedef struct packed {
        logic [31:0]      addr;
        cache_pkg::line_t data;
    } mem_wr_req_t;

    // one refill beat where last marks the fourth
    typedef struct packed {
        cache_pkg::word_t data;
        logic             last;
    } mem_ret_t;

endpackage

`default_nettype wire

// File: hw/sync_sram.sv
`timescale 1ns/1ns
`default_nettype none

module sync_sram #(
    parameter int  DEPTH     = cache_pkg::NUM_SETS,
    parameter type payload_t = cache_pkg::word_t
) (
    input  wire                      clk,
    input  wire                      we,
    input  wire cache_pkg::index_t   addr,
    input  wire payload_t            wdata,
    output payload_t                 rdata
);

    payload_t mem [DEPTH];

    // read-before-write on the same address
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

    assert property (@(posedge clk) we |-> (int'(addr) < DEPTH))
        else $error("sync_sram: write address %0d beyond depth %0d", addr, DEPTH);

endmodule

`default_nettype wire

// File: hw/cache_way.sv
`timescale 1ns/1ns
`default_nettype none

module cache_way #(
    parameter int DEPTH = cache_pkg::NUM_SETS
) (
    input  wire                           clk,
    input  wire                           resetn,
    input  wire cache_pkg::index_t        index,
    input  wire cache_pkg::tag_t          lookup_tag,
    input  wire [cache_pkg::OFFSET_W-1:0] offset,
    input  wire cache_pkg::way_write_t    wr,
    output cache_pkg::way_status_t        status
);

    cache_pkg::tag_t                ram_tag;
    cache_pkg::line_t               ram_line;
    logic [DEPTH-1:0]               valid_bits;
    logic [DEPTH-1:0]               dirty_bits;
    logic [cache_pkg::OFFSET_W-3:0] word_sel;
    logic                           hit;

    sync_sram #(
        .DEPTH     (DEPTH),
        .payload_t (cache_pkg::tag_t)
    ) tag_ram (
        .clk   (clk),
        .we    (wr.tag_we),
        .addr  (index),
        .wdata (wr.tag),
        .rdata (ram_tag)
    );

    sync_sram #(
        .DEPTH     (DEPTH),
        .payload_t (cache_pkg::line_t)
    ) data_ram (
        .clk   (clk),
        .we    (wr.line_we),
        .addr  (index),
        .wdata (wr.line),
        .rdata (ram_line)
    );

    // valid is set by a refill and dirty follows each line write
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (wr.tag_we) begin
                valid_bits[index] <= 1'b1;
            end
            if (wr.line_we) begin
                dirty_bits[index] <= wr.dirty;
            end
        end
    end

    assign word_sel = offset[cache_pkg::OFFSET_W-1:2];
    assign hit      = valid_bits[index] && (ram_tag == lookup_tag);

    always_comb begin
        status.hit       = hit;
        status.valid     = valid_bits[index];
        status.dirty     = dirty_bits[index];
        status.tag       = ram_tag;
        status.line      = ram_line;
        status.load_word = ram_line[word_sel*32 +: 32];
    end

    // store hits only touch a line this way already holds
    assert property (@(posedge clk) disable iff (!resetn)
        wr.line_we |-> (wr.tag_we || (wr.dirty && hit)))
        else $error("cache_way: line write without refill or store hit");

endmodule

`default_nettype wire

// File: hw/cache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl #(
    parameter logic [22:0] LFSR_SEED = 23'b100_1010_0101_0010_1000_1010
) (
    input  wire                            clk,
    input  wire                            resetn,
    input  wire                            valid,
    input  wire cache_pkg::cpu_req_t       req,
    output logic                           addr_ok,
    output logic                           data_ok,
    output cache_pkg::word_t               rdata,
    input  wire cache_pkg::way_status_t    way0_status,
    input  wire cache_pkg::way_status_t    way1_status,
    output cache_pkg::index_t              index,
    output cache_pkg::tag_t                lookup_tag,
    output logic [cache_pkg::OFFSET_W-1:0] offset,
    output cache_pkg::way_write_t          way0_wr,
    output cache_pkg::way_write_t          way1_wr,
    output logic                           rd_req,
    output mem_bus_pkg::mem_rd_req_t       rd_addr,
    input  wire                            rd_rdy,
    input  wire                            ret_valid,
    input  wire mem_bus_pkg::mem_ret_t     ret,
    output logic                           wr_req,
    output mem_bus_pkg::mem_wr_req_t       wr,
    input  wire                            wr_rdy
);

    cache_pkg::cache_state_t        state;
    cache_pkg::cache_state_t        state_nxt;
    cache_pkg::cpu_req_t            req_r;
    logic [22:0]                    lfsr;
    logic [1:0]                     beat_cnt;
    logic [cache_pkg::OFFSET_W-3:0] word_sel;
    cache_pkg::line_t               fill_line;
    cache_pkg::line_t               refill_line;
    cache_pkg::word_t               beat_word;
    cache_pkg::way_sel_t            pick;
    cache_pkg::way_sel_t            victim_way;
    logic                           pick_dirty;
    logic                           cache_hit;
    logic                           in_lookup;
    logic                           refill_done;

    function automatic cache_pkg::word_t merge_word(
        input cache_pkg::word_t old_word,
        input cache_pkg::word_t new_word,
        input cache_pkg::strb_t strb
    );
        cache_pkg::word_t res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic cache_pkg::line_t put_word(
        input cache_pkg::line_t line,
        input logic [1:0]       sel,
        input cache_pkg::word_t word
    );
        cache_pkg::line_t res;
        res = line;
        res[sel*32 +: 32] = word;
        return res;
    endfunction

    assign addr_ok     = (state == cache_pkg::idle);
    assign in_lookup   = (state == cache_pkg::lookup);
    assign cache_hit   = way0_status.hit || way1_status.hit;
    assign refill_done = (state == cache_pkg::refill) && ret_valid && ret.last;
    assign word_sel    = req_r.addr.offset[cache_pkg::OFFSET_W-1:2];

    // RAMs see the incoming index while idle so lookup has data next cycle
    assign index      = addr_ok ? req.addr.index : req_r.addr.index;
    assign lookup_tag = req_r.addr.tag;
    assign offset     = req_r.addr.offset;

    always_comb begin
        state_nxt = state;
        case (state)
            cache_pkg::idle:    if (valid) state_nxt = cache_pkg::lookup;
            cache_pkg::lookup: begin
                if (cache_hit) begin
                    state_nxt = cache_pkg::idle;
                end else if (pick_dirty) begin
                    state_nxt = cache_pkg::miss;
                end else begin
                    state_nxt = cache_pkg::replace;
                end
            end
            cache_pkg::miss:    if (wr_rdy) state_nxt = cache_pkg::replace;
            cache_pkg::replace: if (rd_rdy) state_nxt = cache_pkg::refill;
            cache_pkg::refill:  if (refill_done) state_nxt = cache_pkg::idle;
            default:            state_nxt = cache_pkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= cache_pkg::idle;
            lfsr     <= LFSR_SEED;
            beat_cnt <= 2'd0;
            data_ok  <= 1'b0;
        end else begin
            state    <= state_nxt;
            lfsr     <= {lfsr[21:0], lfsr[22] ^ lfsr[17]};
            data_ok  <= (in_lookup && cache_hit) || refill_done;
            if (state != cache_pkg::refill) begin
                beat_cnt <= 2'd0;
            end else if (ret_valid) begin
                beat_cnt <= beat_cnt + 2'd1;
            end
        end
    end

    // invalid way first, else random
    always_comb begin
        if (!way0_status.valid) begin
            pick = 1'b0;
        end else if (!way1_status.valid) begin
            pick = 1'b1;
        end else begin
            pick = lfsr[0];
        end
        pick_dirty = pick ? (way1_status.valid && way1_status.dirty)
                          : (way0_status.valid && way0_status.dirty);
    end

    // store bytes land on the requested word as it streams in
    assign beat_word   = (req_r.op && beat_cnt == word_sel)
                       ? merge_word(ret.data, req_r.wdata, req_r.wstrb) : ret.data;
    assign refill_line = put_word(fill_line, beat_cnt, beat_word);

    always_ff @(posedge clk) begin
        if (addr_ok && valid) begin
            req_r <= req;
        end
        if (in_lookup) begin
            victim_way <= pick;
            wr.addr    <= {pick ? way1_status.tag : way0_status.tag, req_r.addr.index,
                           {cache_pkg::OFFSET_W{1'b0}}};
            wr.data    <= pick ? way1_status.line : way0_status.line;
        end
        if (ret_valid) begin
            fill_line <= refill_line;
        end
        if (in_lookup && cache_hit) begin
            rdata <= way0_status.hit ? way0_status.load_word : way1_status.load_word;
        end else if (ret_valid && beat_cnt == word_sel) begin
            rdata <= beat_word;
        end
    end

    always_comb begin
        way0_wr.tag_we  = refill_done && (victim_way == 1'b0);
        way1_wr.tag_we  = refill_done && (victim_way == 1'b1);
        way0_wr.line_we = refill_done ? !victim_way
                                      : (in_lookup && way0_status.hit && req_r.op);
        way1_wr.line_we = refill_done ? victim_way
                                      : (in_lookup && way1_status.hit && req_r.op);
        way0_wr.dirty   = req_r.op;
        way1_wr.dirty   = req_r.op;
        way0_wr.tag     = req_r.addr.tag;
        way1_wr.tag     = req_r.addr.tag;
        way0_wr.line    = refill_done ? refill_line
                        : put_word(way0_status.line, word_sel,
                                   merge_word(way0_status.load_word, req_r.wdata, req_r.wstrb));
        way1_wr.line    = refill_done ? refill_line
                        : put_word(way1_status.line, word_sel,
                                   merge_word(way1_status.load_word, req_r.wdata, req_r.wstrb));
    end

    assign wr_req  = (state == cache_pkg::miss);
    assign rd_req  = (state == cache_pkg::replace);
    assign rd_addr = {req_r.addr.tag, req_r.addr.index, {cache_pkg::OFFSET_W{1'b0}}};

    // a tag lives in at most one way of a set
    assert property (@(posedge clk) disable iff (!resetn)
        in_lookup |-> !(way0_status.hit && way1_status.hit))
        else $error("cache_ctrl: both ways hit");

    assert property (@(posedge clk) disable iff (!resetn)
        ret_valid |-> (state == cache_pkg::refill))
        else $error("cache_ctrl: refill beat outside refill");

endmodule

`default_nettype wire

// File: hw/cache_top.sv
`timescale 1ns/1ns
`default_nettype none

module cache_top #(
    parameter int          DEPTH     = cache_pkg::NUM_SETS,
    parameter logic [22:0] LFSR_SEED = 23'b100_1010_0101_0010_1000_1010
) (
    input  wire                         clk,
    input  wire                         resetn,
    // cpu
    input  wire                         valid,
    input  wire cache_pkg::cpu_req_t    req,
    output logic                        addr_ok,
    output logic                        data_ok,
    output cache_pkg::word_t            rdata,
    // memory read
    output logic                        rd_req,
    output mem_bus_pkg::mem_rd_req_t    rd_addr,
    input  wire                         rd_rdy,
    input  wire                         ret_valid,
    input  wire mem_bus_pkg::mem_ret_t  ret,
    // memory write
    output logic                        wr_req,
    output mem_bus_pkg::mem_wr_req_t    wr,
    input  wire                         wr_rdy
);

    cache_pkg::index_t              index;
    cache_pkg::tag_t                lookup_tag;
    logic [cache_pkg::OFFSET_W-1:0] offset;
    cache_pkg::way_status_t         way0_status;
    cache_pkg::way_status_t         way1_status;
    cache_pkg::way_write_t          way0_wr;
    cache_pkg::way_write_t          way1_wr;

    cache_ctrl #(
        .LFSR_SEED (LFSR_SEED)
    ) u_ctrl (
        .clk         (clk),
        .resetn      (resetn),
        .valid       (valid),
        .req         (req),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .way0_status (way0_status),
        .way1_status (way1_status),
        .index       (index),
        .lookup_tag  (lookup_tag),
        .offset      (offset),
        .way0_wr     (way0_wr),
        .way1_wr     (way1_wr),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .ret         (ret),
        .wr_req      (wr_req),
        .wr          (wr),
        .wr_rdy      (wr_rdy)
    );

    cache_way #(
        .DEPTH (DEPTH)
    ) u_way0 (
        .clk        (clk),
        .resetn     (resetn),
        .index      (index),
        .lookup_tag (lookup_tag),
        .offset     (offset),
        .wr         (way0_wr),
        .status     (way0_status)
    );

    cache_way #(
        .DEPTH (DEPTH)
    ) u_way1 (
        .clk        (clk),
        .resetn     (resetn),
        .index      (index),
        .lookup_tag (lookup_tag),
        .offset     (offset),
        .wr         (way1_wr),
        .status     (way1_status)
    );

endmodule

`default_nettype wire

// File: verification/cache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cache_tb;

    localparam int TIMEOUT = 500;

    logic                     clk;
    logic                     resetn;
    logic                     valid;
    cache_pkg::cpu_req_t      req;
    logic                     addr_ok;
    logic                     data_ok;
    cache_pkg::word_t         rdata;
    logic                     rd_req;
    mem_bus_pkg::mem_rd_req_t rd_addr;
    logic                     rd_rdy;
    logic                     ret_valid;
    mem_bus_pkg::mem_ret_t    ret;
    logic                     wr_req;
    mem_bus_pkg::mem_wr_req_t wr;
    logic                     wr_rdy;

    // keyed by word-aligned byte address
    cache_pkg::word_t mem_words [int unsigned];
    cache_pkg::word_t model_words [int unsigned];

    int                       rd_count = 0;
    int                       wr_count = 0;
    mem_bus_pkg::mem_rd_req_t last_rd_addr;
    logic [31:0]              pending_addr;
    int                       value_errors = 0;
    int                       count_errors = 0;
    int                       timeout_errors = 0;

    cache_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int unsigned key_of(input logic [31:0] addr);
        return {addr[31:2], 2'b00};
    endfunction

    // odd multiplier gives each untouched word a distinct value
    function automatic cache_pkg::word_t fill_word(input logic [31:0] addr);
        return addr * 32'h9e37_79b1 + 32'h3c96_a55a;
    endfunction

    function automatic cache_pkg::word_t mem_word(input logic [31:0] addr);
        if (mem_words.exists(key_of(addr))) begin
            return mem_words[key_of(addr)];
        end
        return fill_word(key_of(addr));
    endfunction

    function automatic cache_pkg::word_t model_word(input logic [31:0] addr);
        if (model_words.exists(key_of(addr))) begin
            return model_words[key_of(addr)];
        end
        return mem_word(addr);
    endfunction

    function automatic cache_pkg::line_t model_line(input logic [31:0] line_addr);
        cache_pkg::line_t line;
        for (int i = 0; i < 4; i++) begin
            line[i*32 +: 32] = model_word(line_addr + 32'(i * 4));
        end
        return line;
    endfunction

    // byte lanes with a strobe take the new data
    function automatic void apply_store(input logic [31:0] addr, input cache_pkg::strb_t strb,
                                        input cache_pkg::word_t data);
        cache_pkg::word_t w;
        w = model_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                w[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        model_words[key_of(addr)] = w;
    endfunction

    task automatic check_word(input string name, input cache_pkg::word_t got,
                              input cache_pkg::word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERR %0t %s got %08h expected %08h", $time, name, got, exp);
        end
    endtask

    task automatic check_line(input mem_bus_pkg::mem_wr_req_t got,
                              input mem_bus_pkg::mem_wr_req_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("ERR %0t wr got %08h:%032h expected %08h:%032h",
                     $time, got.addr, got.data, exp.addr, exp.data);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            count_errors++;
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("errors: value %0d count %0d timeout %0d",
                 value_errors, count_errors, timeout_errors);
        if (value_errors + count_errors + timeout_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic serve_reads();
        int                    gap;
        logic [31:0]           base;
        mem_bus_pkg::mem_ret_t beat;
        forever begin
            @(posedge clk);
            if (resetn && rd_req) begin
                repeat ($urandom_range(0, 3)) begin
                    @(posedge clk);
                end
                rd_rdy <= 1'b1;
                @(posedge clk);
                rd_rdy <= 1'b0;
                base = rd_addr;
                last_rd_addr = rd_addr;
                rd_count++;
                for (int i = 0; i < 4; i++) begin
                    gap = $urandom_range(0, 2);
                    repeat (gap) begin
                        ret_valid <= 1'b0;
                        @(posedge clk);
                    end
                    beat.data = mem_word(base + 32'(i * 4));
                    beat.last = (i == 3);
                    ret_valid <= 1'b1;
                    ret       <= beat;
                    @(posedge clk);
                end
                ret_valid <= 1'b0;
            end
        end
    endtask

    task automatic serve_writes();
        mem_bus_pkg::mem_wr_req_t exp;
        forever begin
            @(posedge clk);
            if (resetn && wr_req) begin
                repeat ($urandom_range(0, 3)) begin
                    @(posedge clk);
                end
                wr_rdy <= 1'b1;
                @(posedge clk);
                wr_rdy <= 1'b0;
                // the victim sits in the same set as the request
                exp.addr = {wr.addr[31:12], pending_addr[11:4], 4'h0};
                exp.data = model_line(exp.addr);
                check_line(wr, exp);
                for (int i = 0; i < 4; i++) begin
                    mem_words[key_of(wr.addr + 32'(i * 4))] = wr.data[i*32 +: 32];
                end
                wr_count++;
            end
        end
    endtask

    task automatic cpu_access(input logic op, input logic [31:0] addr,
                              input cache_pkg::strb_t wstrb, input cache_pkg::word_t wdata,
                              output cache_pkg::word_t data, output int cycles);
        cache_pkg::cpu_req_t r;
        int                  wait_cnt;
        r.op    = op;
        r.addr  = addr;
        r.wstrb = wstrb;
        r.wdata = wdata;
        pending_addr = addr;
        @(posedge clk);
        valid <= 1'b1;
        req   <= r;
        wait_cnt = 0;
        do begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > TIMEOUT) begin
                $display("timeout: request to %08h was never accepted", addr);
                timeout_errors++;
                finish_run();
            end
        end while (!addr_ok);
        valid  <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("timeout: no data_ok for request to %08h", addr);
                timeout_errors++;
                finish_run();
            end
        end while (!data_ok);
        data = rdata;
    endtask

    task automatic read_check(input logic [31:0] addr, output int cycles);
        cache_pkg::word_t data;
        cpu_access(1'b0, addr, 4'h0, 32'h0, data, cycles);
        check_word("rdata", data, model_word(addr));
    endtask

    task automatic write_model(input logic [31:0] addr, input cache_pkg::strb_t strb,
                               input cache_pkg::word_t data, output int cycles);
        cache_pkg::word_t unused;
        apply_store(addr, strb, data);
        cpu_access(1'b1, addr, strb, data, unused, cycles);
    endtask

    task automatic test_read_miss();
        int rd0;
        int wr0;
        int cycles;
        rd0 = rd_count;
        wr0 = wr_count;
        read_check(32'h0001_2344, cycles);
        check_count("rd_req count", rd_count - rd0, 1);
        check_count("wr_req count", wr_count - wr0, 0);
        check_word("rd_addr", last_rd_addr, 32'h0001_2340);
    endtask

    task automatic test_hits();
        int rd0;
        int cycles;
        rd0 = rd_count;
        read_check(32'h0001_234c, cycles);
        check_count("data_ok latency", cycles, 2);
        write_model(32'h0001_2348, 4'b0110, 32'hdead_beef, cycles);
        check_count("data_ok latency", cycles, 2);
        read_check(32'h0001_2348, cycles);
        check_count("rd_req count", rd_count - rd0, 0);
    endtask

    task automatic test_write_miss();
        int rd0;
        int cycles;
        rd0 = rd_count;
        write_model(32'h0002_5678, 4'b1001, 32'h1234_5678, cycles);
        check_count("rd_req count", rd_count - rd0, 1);
        read_check(32'h0002_5678, cycles);
        read_check(32'h0002_5674, cycles);
    endtask

    // three tags on index 0x50 cannot all fit in two ways
    task automatic test_evict();
        logic [31:0] addrs [3];
        int          wr0;
        int          cycles;
        addrs = '{32'h00a0_0504, 32'h00b1_1508, 32'h00c2_250c};
        wr0 = wr_count;
        for (int i = 0; i < 3; i++) begin
            write_model(addrs[i], 4'hf, 32'h5000_0000 + 32'(i), cycles);
        end
        if (wr_count - wr0 < 1) begin
            count_errors++;
            $display("no write-back seen after three dirty lines on one index");
        end
        for (int i = 0; i < 3; i++) begin
            read_check(addrs[i], cycles);
        end
    endtask

    task automatic test_random();
        logic [31:0] addr;
        int          cycles;
        for (int n = 0; n < 200; n++) begin
            addr = 32'h3000_0200 + 32'($urandom_range(0, 3)) * 32'h0011_1000
                 + 32'($urandom_range(0, 3)) * 32'h10 + 32'($urandom_range(0, 3)) * 32'h4;
            if ($urandom_range(0, 1) == 1) begin
                write_model(addr, cache_pkg::strb_t'($urandom_range(1, 15)), $urandom, cycles);
            end else begin
                read_check(addr, cycles);
            end
        end
    endtask

    initial begin
        void'($urandom(32'h575817a2));
        resetn    = 1'b0;
        valid     = 1'b0;
        req       = '0;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret       = '0;
        wr_rdy    = 1'b0;
        fork
            serve_reads();
            serve_writes();
        join_none
        repeat (10) @(posedge clk);
        resetn <= 1'b1;
        test_read_miss();
        test_hits();
        test_write_miss();
        test_evict();
        test_random();
        finish_run();
    end

endmodule

`default_nettype wire

// File: cache_top.f
hw/cache_pkg.sv
hw/mem_bus_pkg.sv
hw/sync_sram.sv
hw/cache_way.sv
hw/cache_ctrl.sv
hw/cache_top.sv
verification/cache_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := cache_tb
FILELIST := cache_top.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

# the log decides the result, whatever the simulator's exit status
run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
